/* list.f */
hdl/lock_pkg.sv
hdl/oversample_filter.sv
hdl/frontpanel_regs.sv
hdl/pid_core.sv
hdl/source_mux.sv
hdl/lock_top.sv
tb/lock_chk.sv
tb/lock_tb.sv

/* Makefile */
# Verilator build and run for the servo-lock testbench

VERILATOR ?= verilator
TOP       ?= lock_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/lock_stimulus.txt */
# C <word> | S <name> <sample0> <sample1> <sample2> <sample3> <expected dac> | R
# all values hex, samples and dac words signed 16 bit, command word 24 bit
# integral only, sp 100 and i 1, dac is the running sum of block errors
C 100064
C 300001
C 8C0000
S avg1 000A 0014 001E 0028 004B
S avg2 0001 0002 0003 0005 00AD
S avg3 FFFD FFFD FFFD FFFC 0115
S avg4 00C8 00C8 00C8 00C8 00B1
# full pid, sp 1000 p 3 i 2 d 1, k1 6 k2 -5 k3 1
R
C 1003E8
C 200003
C 300002
C 400001
C 8C0000
S pid1 0320 0320 0320 0320 04B0
S pid2 0384 0384 0384 0384 0320
S pid3 044C 044C 044C 044C FF9C
S pid4 03E8 03EA 03E6 03E9 01F4
# staged p 10, ignored until an update with update_en high
C 20000A
S stg1 03E8 03E8 03E8 03E8 0190
C 840000
S stg2 03DE 03DE 03DE 03DE 01CC
C 8C0000
S stg3 03DE 03DE 03DE 03DE 01D6
# clear, next output is k1 times e alone
C 8A0000
S clr1 03D4 03D4 03D4 03D4 0104
S clr2 03E8 03E8 03E8 03E8 0014
# saturation with sp 0 and p 100
R
C 200064
C 8C0000
S sat1 03E8 03E8 03E8 03E8 8000
S sat2 0000 0000 0000 0000 0000
S sat3 FC18 FC18 FC18 FC18 7FFF
# manual source while the pid keeps running
C 50FB2E
C 890000
S man1 FC18 FC18 FC18 FC18 FB2E
C 500300
S man2 0000 0000 0000 0000 0300
C 880000
S back1 0032 0032 0032 0032 EC78

/* tb/lock_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lock_tb;

	import lock_pkg::*;

	localparam int W_ADC        = 16;                // adc width
	localparam int OS_LOG2      = 2;                 // 4-sample blocks
	localparam int W_IN         = 18;                // filter out / pid in
	localparam int W_OUT        = 18;                // pid accumulator
	localparam int COMP_LATENCY = 1;                 // pid compute cycles
	localparam int DAC_TIMEOUT  = 20;                // cycles per dac wait
	localparam int LATENCY_EXP  = COMP_LATENCY + 3;  // last sample -> dac strobe

	logic                    clk_in;
	logic                    reset_in;
	logic signed [W_ADC-1:0] adc_data;
	logic                    adc_valid;
	lock_cmd_u               cmd_word;
	logic                    cmd_valid;
	logic signed [W_DAC-1:0] dac_data;
	logic                    dac_valid;

	int tests;                                       // blocks run
	int passed;                                      // blocks without failure
	int errors;                                      // failed checks
	int dac_count;                                   // dac strobes seen

	lock_top #(
		.W_ADC(W_ADC), .OS_LOG2(OS_LOG2), .W_IN(W_IN),
		.W_OUT(W_OUT), .COMP_LATENCY(COMP_LATENCY)
	) uut (
		.clk_in(clk_in), .reset_in(reset_in),
		.adc_data(adc_data), .adc_valid(adc_valid),
		.cmd_word(cmd_word), .cmd_valid(cmd_valid),
		.dac_data(dac_data), .dac_valid(dac_valid)
	);

	initial begin
		clk_in = 1'b0;
		forever #20 clk_in = ~clk_in;                // 40 ns period
	end

	always @(negedge clk_in) begin
		if (!reset_in && dac_valid) dac_count = dac_count + 1;  // mid-cycle, stable
	end

	////////////////////////////////////////
	// drive helpers
	////////////////////////////////////////

	task automatic drive_slot();
		@(posedge clk_in);
		#2;                                          // inputs change after the edge
	endtask

	task automatic apply_reset();
		reset_in  = 1'b1;
		adc_valid = 1'b0;
		cmd_valid = 1'b0;
		for (int c = 0; c < 4; c++) drive_slot();    // 4 reset edges
		reset_in = 1'b0;
	endtask

	task automatic send_command(input logic [23:0] word);
		drive_slot();
		cmd_word  = word;
		cmd_valid = 1'b1;
		drive_slot();
		cmd_valid = 1'b0;
		for (int c = 0; c < 2; c++) drive_slot();    // strobe reaches pid
	endtask

	function automatic logic [63:0] tag_of(input logic [7:0] ch);
		return {56'd0, ch};                          // %s right-justifies
	endfunction

	////////////////////////////////////////
	// one block of samples and its dac check
	////////////////////////////////////////

	task automatic run_block(input logic [8*16-1:0] name, input logic [W_ADC-1:0] s0,
			input logic [W_ADC-1:0] s1, input logic [W_ADC-1:0] s2,
			input logic [W_ADC-1:0] s3, input logic [W_DAC-1:0] expected);
		logic [W_ADC-1:0] samples [4];
		logic [W_DAC-1:0] actual;
		int               n;
		bit               seen;
		bit               bad;
		samples[0] = s0;
		samples[1] = s1;
		samples[2] = s2;
		samples[3] = s3;
		actual = '0;
		n      = 1;                                  // cycle that carried the last sample
		seen   = 1'b0;
		bad    = 1'b0;
		for (int k = 0; k < 4; k++) begin
			drive_slot();
			adc_data  = samples[k];
			adc_valid = 1'b1;
		end
		drive_slot();                                // edge that took the last sample
		adc_valid = 1'b0;
		adc_data  = '0;
		while (!seen && n < DAC_TIMEOUT) begin
			@(posedge clk_in);
			#1;
			n++;
			if (dac_valid) begin
				seen   = 1'b1;
				actual = dac_data;
			end
		end
		tests++;
		if (!seen) begin
			$display("timeout: no dac_valid within %0d cycles in test %0s", DAC_TIMEOUT, name);
			errors++;
			bad = 1'b1;
		end else begin
			if (actual != expected) begin
				$display("mismatch in test %0s: dac word expected %h, actual %h",
					name, expected, actual);
				errors++;
				bad = 1'b1;
			end
			if (n != LATENCY_EXP) begin
				$display("mismatch in test %0s: latency expected %0d, actual %0d",
					name, LATENCY_EXP, n);
				errors++;
				bad = 1'b1;
			end
		end
		if (bad) begin
			$display("test %0s failed", name);
		end else begin
			passed++;
			$display("test %0s passed, dac %h after %0d cycles", name, actual, n);
		end
		for (int c = 0; c < 4; c++) drive_slot();    // gap before next block
	endtask

	////////////////////////////////////////
	// stimulus file
	////////////////////////////////////////

	initial begin
		int               fd;
		int               code;
		bit               done;
		logic [63:0]      tag;
		logic [8*16-1:0]  name;
		logic [23:0]      word;
		logic [15:0]      s0;
		logic [15:0]      s1;
		logic [15:0]      s2;
		logic [15:0]      s3;
		logic [15:0]      expected;
		logic [8*256-1:0] line;
		reset_in  = 1'b1;
		adc_data  = '0;
		adc_valid = 1'b0;
		cmd_word  = '0;
		cmd_valid = 1'b0;
		tests     = 0;
		passed    = 0;
		errors    = 0;
		dac_count = 0;
		done      = 1'b0;
		apply_reset();
		fd = $fopen("tb/lock_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open tb/lock_stimulus.txt");
			errors++;
			done = 1'b1;
		end
		while (!done) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) begin
				done = 1'b1;                         // end of file
			end else if (tag == tag_of("#")) begin
				code = $fgets(line, fd);             // skip comment line
			end else if (tag == tag_of("C")) begin
				code = $fscanf(fd, "%h", word);
				if (code != 1) begin
					$display("command record without a word in the stimulus file");
					errors++;
					done = 1'b1;
				end else begin
					send_command(word);
				end
			end else if (tag == tag_of("S")) begin
				code = $fscanf(fd, "%s %h %h %h %h %h", name, s0, s1, s2, s3, expected);
				if (code != 6) begin
					$display("sample record with missing fields in the stimulus file");
					errors++;
					done = 1'b1;
				end else begin
					run_block(name, s0, s1, s2, s3, expected);
				end
			end else if (tag == tag_of("R")) begin
				apply_reset();
			end else begin
				$display("unknown record tag in the stimulus file");
				errors++;
				done = 1'b1;
			end
		end
		if (fd != 0) $fclose(fd);
		if (dac_count != tests) begin
			$display("mismatch in test strobe_count: dac strobes expected %0d, actual %0d",
				tests, dac_count);
			errors++;
		end
		$display("tests: %0d  passed: %0d  failed: %0d  errors: %0d",
			tests, passed, tests - passed, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* tb/lock_chk.sv */
`timescale 1ns/10ps
`default_nettype none

module lock_chk (
	input wire clk_in,                               // system clock
	input wire reset_in,                             // sync reset
	input wire filt_valid,                           // filter strobe
	input wire pid_valid,                            // pid strobe
	input wire dac_valid                             // dac strobe
);

	////////////////////////////////////////
	// strobe protocol
	////////////////////////////////////////

	a_dac_after_pid: assert property (@(posedge clk_in) disable iff (reset_in)
		pid_valid |=> dac_valid)
		else $error("dac_valid missing one cycle after pid_valid");

	a_dac_only_after_pid: assert property (@(posedge clk_in) disable iff (reset_in)
		!pid_valid |=> !dac_valid)
		else $error("dac_valid without pid_valid one cycle earlier");

	a_pid_one_cycle: assert property (@(posedge clk_in) disable iff (reset_in)
		pid_valid |=> !pid_valid)
		else $error("pid_valid held longer than one cycle");

	a_filt_spaced: assert property (@(posedge clk_in) disable iff (reset_in)
		filt_valid |=> !filt_valid)
		else $error("filt_valid high in two adjacent cycles");

	// registered strobes are low from the cycle after reset is seen
	a_quiet_in_reset: assert property (@(posedge clk_in)
		reset_in |=> !(filt_valid || pid_valid || dac_valid))
		else $error("valid strobe during reset");

endmodule

bind lock_top lock_chk chk (
	.clk_in(clk_in),
	.reset_in(reset_in),
	.filt_valid(filt_valid),
	.pid_valid(pid_valid),
	.dac_valid(dac_valid)
);

`default_nettype wire

/* hdl/lock_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lock_top #(
	parameter int W_ADC        = 16,                 // adc width
	parameter int OS_LOG2      = 2,                  // 4-sample blocks
	parameter int W_IN         = 18,                 // filter / pid input width
	parameter int W_OUT        = 18,                 // pid accumulator width
	parameter int COMP_LATENCY = 1                   // pid compute cycles
) (
	input  wire                                clk_in,     // system clock
	input  wire                                reset_in,   // sync reset
	input  wire signed [W_ADC-1:0]             adc_data,   // adc sample
	input  wire                                adc_valid,  // sample strobe
	input  wire lock_pkg::lock_cmd_u           cmd_word,   // front-panel command
	input  wire                                cmd_valid,  // command strobe
	output logic signed [lock_pkg::W_DAC-1:0]  dac_data,   // dac word
	output logic                               dac_valid   // dac strobe
);

	import lock_pkg::*;

	logic signed [W_IN-1:0]   filt_data;             // filter -> pid
	logic                     filt_valid;
	logic signed [W_COEF-1:0] setpoint, p_coef, i_coef, d_coef;  // staged params
	logic signed [W_COEF-1:0] manual_value;
	logic                     update_en, update, clear, use_manual;
	logic signed [W_OUT-1:0]  pid_data;              // pid -> mux
	logic                     pid_valid;

	////////////////////////////////////////
	// datapath
	////////////////////////////////////////

	oversample_filter #(.W_ADC(W_ADC), .W_IN(W_IN), .OS_LOG2(OS_LOG2)) u_filter (
		.clk_in(clk_in), .reset_in(reset_in),
		.adc_data(adc_data), .adc_valid(adc_valid),
		.filt_data(filt_data), .filt_valid(filt_valid)
	);

	frontpanel_regs u_regs (
		.clk_in(clk_in), .reset_in(reset_in),
		.cmd_word(cmd_word), .cmd_valid(cmd_valid),
		.setpoint(setpoint), .p_coef(p_coef), .i_coef(i_coef), .d_coef(d_coef),
		.manual_value(manual_value), .update_en(update_en), .update(update),
		.clear(clear), .use_manual(use_manual)
	);

	pid_core #(.W_IN(W_IN), .W_OUT(W_OUT), .COMP_LATENCY(COMP_LATENCY)) u_pid (
		.clk_in(clk_in), .reset_in(reset_in),
		.data(filt_data), .data_valid(filt_valid),
		.setpoint(setpoint), .p_coef(p_coef), .i_coef(i_coef), .d_coef(d_coef),
		.update_en(update_en), .update(update), .clear(clear),
		.pid_data(pid_data), .pid_valid(pid_valid)
	);

	source_mux #(.W_OUT(W_OUT)) u_mux (
		.clk_in(clk_in), .reset_in(reset_in),
		.pid_data(pid_data), .pid_valid(pid_valid),
		.manual_value(manual_value), .use_manual(use_manual),
		.dac_data(dac_data), .dac_valid(dac_valid)
	);

endmodule

`default_nettype wire

/* hdl/source_mux.sv */
`timescale 1ns/10ps
`default_nettype none

module source_mux #(
	parameter int W_OUT = 18                         // pid output width
) (
	input  wire                                 clk_in,        // system clock
	input  wire                                 reset_in,      // sync reset
	input  wire signed [W_OUT-1:0]              pid_data,      // pid value
	input  wire                                 pid_valid,     // pid strobe
	input  wire signed [lock_pkg::W_COEF-1:0]   manual_value,  // manual value
	input  wire                                 use_manual,    // source select
	output logic signed [lock_pkg::W_DAC-1:0]   dac_data,      // dac word
	output logic                                dac_valid      // dac strobe
);

	import lock_pkg::*;

	localparam int W_A   = (W_OUT > W_COEF) ? W_OUT : W_COEF;
	localparam int W_SEL = (W_A > W_DAC) ? W_A : W_DAC;      // widest operand
	localparam logic signed [W_SEL-1:0] D_MAX = W_SEL'((2 ** (W_DAC-1)) - 1);
	localparam logic signed [W_SEL-1:0] D_MIN = ~D_MAX;      // most negative dac

	logic signed [W_SEL-1:0] sel_val;                // chosen source
	logic signed [W_DAC-1:0] sat_val;                // clamped to dac range

	assign sel_val = use_manual ? W_SEL'(manual_value) : W_SEL'(pid_data);

	always_comb begin
		if (sel_val > D_MAX) begin
			sat_val = D_MAX[W_DAC-1:0];
		end else if (sel_val < D_MIN) begin
			sat_val = D_MIN[W_DAC-1:0];
		end else begin
			sat_val = sel_val[W_DAC-1:0];
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			dac_valid <= 1'b0;
		end else begin
			dac_valid <= pid_valid;                  // one cycle behind pid
		end
		if (pid_valid) begin
			dac_data <= sat_val;                     // manual rides pid rate
		end
	end

endmodule

`default_nettype wire

/* hdl/pid_core.sv */
`timescale 1ns/10ps
`default_nettype none

module pid_core #(
	parameter int W_IN         = 18,                 // input width
	parameter int W_OUT        = 18,                 // accumulator width
	parameter int COMP_LATENCY = 1                   // compute cycles
) (
	input  wire                                 clk_in,      // system clock
	input  wire                                 reset_in,    // sync reset
	input  wire signed [W_IN-1:0]               data,        // block average
	input  wire                                 data_valid,  // average strobe
	input  wire signed [lock_pkg::W_COEF-1:0]   setpoint,    // staged setpoint
	input  wire signed [lock_pkg::W_COEF-1:0]   p_coef,      // staged p
	input  wire signed [lock_pkg::W_COEF-1:0]   i_coef,      // staged i
	input  wire signed [lock_pkg::W_COEF-1:0]   d_coef,      // staged d
	input  wire                                 update_en,   // arms update
	input  wire                                 update,      // copy staged -> active
	input  wire                                 clear,       // zero history
	output logic signed [W_OUT-1:0]             pid_data,    // control value
	output logic                                pid_valid    // control strobe
);

	import lock_pkg::*;

	localparam int W_K   = 18;                       // z-domain coef width
	localparam int W_SUM = W_K + W_COEF + 2;         // product sum width
	localparam int W_CNT = (COMP_LATENCY > 1) ? $clog2(COMP_LATENCY) : 1;
	localparam logic [W_CNT-1:0] CNT_LAST = W_CNT'(COMP_LATENCY - 1);

	localparam logic signed [W_IN:0] E_MAX = (W_IN+1)'((2 ** (W_COEF-1)) - 1);
	localparam logic signed [W_IN:0] E_MIN = ~E_MAX; // -E_MAX-1

	localparam logic [1:0] ST_IDLE    = 2'd0,        // wait for sample
	                       ST_COMPUTE = 2'd1,        // arithmetic settles
	                       ST_SEND    = 2'd2,        // output strobe
	                       ST_DONE    = 2'd3;        // shift history

	logic [1:0]               state, next_state;
	logic [W_CNT-1:0]         counter;               // cycles in compute
	logic signed [W_IN-1:0]   data_reg;              // latched sample
	logic signed [W_COEF-1:0] sp_act, p_act, i_act, d_act;  // active params
	logic signed [W_IN:0]     e_diff;                // unsaturated error
	logic signed [W_COEF-1:0] e_cur, e_reg, e1, e2;  // error and history
	logic signed [W_K-1:0]    k1, k2, k3;
	logic signed [W_SUM-1:0]  delta_u;
	logic signed [W_OUT-1:0]  u_cur, u_out, u_prev;

	////////////////////////////////////////
	// arithmetic
	////////////////////////////////////////

	assign e_diff = (W_IN+1)'(sp_act) - (W_IN+1)'(data_reg);

	always_comb begin
		if (e_diff > E_MAX) begin
			e_cur = E_MAX[W_COEF-1:0];                   // clamp high
		end else if (e_diff < E_MIN) begin
			e_cur = E_MIN[W_COEF-1:0];                   // clamp low
		end else begin
			e_cur = e_diff[W_COEF-1:0];
		end
	end

	assign k1 = W_K'(p_act) + W_K'(i_act) + W_K'(d_act);
	assign k2 = -W_K'(p_act) - (W_K'(d_act) <<< 1);
	assign k3 = W_K'(d_act);

	assign delta_u = W_SUM'(k1) * W_SUM'(e_cur)
	               + W_SUM'(k2) * W_SUM'(e1)
	               + W_SUM'(k3) * W_SUM'(e2);
	assign u_cur   = u_prev + W_OUT'(delta_u);       // wraps to W_OUT

	assign pid_data  = u_out;
	assign pid_valid = (state == ST_SEND);

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (data_valid && state == ST_IDLE) begin
			data_reg <= data;                            // dropped when busy
		end
		if (state == ST_COMPUTE && counter == CNT_LAST) begin
			u_out <= u_cur;                              // freeze result
			e_reg <= e_cur;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			sp_act <= '0;
			p_act  <= '0;
			i_act  <= '0;
			d_act  <= '0;
		end else if (update && update_en) begin
			sp_act <= setpoint;
			p_act  <= p_coef;
			i_act  <= i_coef;
			d_act  <= d_coef;
		end
	end

	always_ff @(posedge clk_in) begin
		if (reset_in || clear) begin                     // clear wins over done
			u_prev <= '0;
			e1     <= '0;
			e2     <= '0;
		end else if (state == ST_DONE) begin
			u_prev <= u_out;
			e1     <= e_reg;
			e2     <= e1;
		end
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			state   <= ST_IDLE;
			counter <= '0;
		end else begin
			state   <= next_state;
			counter <= (state == ST_COMPUTE && next_state == ST_COMPUTE) ? counter + 1'b1 : '0;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_IDLE:    if (data_valid) next_state = ST_COMPUTE;
			ST_COMPUTE: if (counter == CNT_LAST) next_state = ST_SEND;
			ST_SEND:    next_state = ST_DONE;
			default:    next_state = ST_IDLE;        // done
		endcase
	end

endmodule

`default_nettype wire

/* hdl/frontpanel_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module frontpanel_regs (
	input  wire                                   clk_in,        // system clock
	input  wire                                   reset_in,      // sync reset
	input  wire lock_pkg::lock_cmd_u              cmd_word,      // command word
	input  wire                                   cmd_valid,     // command strobe
	output logic signed [lock_pkg::W_COEF-1:0]    setpoint,      // staged setpoint
	output logic signed [lock_pkg::W_COEF-1:0]    p_coef,        // staged p
	output logic signed [lock_pkg::W_COEF-1:0]    i_coef,        // staged i
	output logic signed [lock_pkg::W_COEF-1:0]    d_coef,        // staged d
	output logic signed [lock_pkg::W_COEF-1:0]    manual_value,  // manual dac value
	output logic                                  update_en,     // update arm level
	output logic                                  update,        // update strobe
	output logic                                  clear,         // clear strobe
	output logic                                  use_manual     // manual select level
);

	import lock_pkg::*;

	////////////////////////////////////////
	// parameter writes
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			setpoint     <= '0;
			p_coef       <= '0;
			i_coef       <= '0;
			d_coef       <= '0;
			manual_value <= '0;
		end else if (cmd_valid) begin
			case (cmd_word.param.sel)
				SEL_SETPOINT: setpoint     <= cmd_word.param.value;
				SEL_P:        p_coef       <= cmd_word.param.value;
				SEL_I:        i_coef       <= cmd_word.param.value;
				SEL_D:        d_coef       <= cmd_word.param.value;
				SEL_MANUAL:   manual_value <= cmd_word.param.value;
				default: ;                                          // ctrl or unknown
			endcase
		end
	end

	////////////////////////////////////////
	// control writes
	////////////////////////////////////////

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			update_en  <= 1'b0;
			use_manual <= 1'b0;
			update     <= 1'b0;
			clear      <= 1'b0;
		end else begin
			update <= 1'b0;                                         // strobes last one cycle
			clear  <= 1'b0;
			if (cmd_valid && cmd_word.ctrl.sel == SEL_CTRL) begin
				update_en  <= cmd_word.ctrl.update_en;
				use_manual <= cmd_word.ctrl.use_manual;
				update     <= cmd_word.ctrl.update;                 // fire if requested
				clear      <= cmd_word.ctrl.clear;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/oversample_filter.sv */
`timescale 1ns/10ps
`default_nettype none

module oversample_filter #(
	parameter int W_ADC   = 16,                     // adc sample width
	parameter int W_IN    = 18,                     // averaged output width
	parameter int OS_LOG2 = 2                       // log2 of block length
) (
	input  wire                     clk_in,         // system clock
	input  wire                     reset_in,       // sync reset
	input  wire signed [W_ADC-1:0]  adc_data,       // raw sample
	input  wire                     adc_valid,      // sample strobe
	output logic signed [W_IN-1:0]  filt_data,      // block average
	output logic                    filt_valid      // average strobe
);

	////////////////////////////////////////
	// block sum
	////////////////////////////////////////

	localparam int W_SUM = W_ADC + OS_LOG2;         // room for 2^OS_LOG2 samples
	localparam logic [OS_LOG2-1:0] CNT_LAST = '1;   // last sample of block

	logic [OS_LOG2-1:0]       count;                // samples so far in block
	logic signed [W_SUM-1:0]  sum;                  // running block sum
	logic signed [W_SUM-1:0]  sum_next;             // sum incl. current sample
	logic signed [W_SUM-1:0]  avg;                  // block mean

	assign sum_next = sum + W_SUM'(adc_data);       // sign extended add
	assign avg      = sum_next >>> OS_LOG2;         // arithmetic divide

	always_ff @(posedge clk_in) begin
		if (reset_in) begin
			count      <= '0;
			sum        <= '0;
			filt_valid <= 1'b0;
		end else begin
			filt_valid <= 1'b0;                     // strobe by default
			if (adc_valid) begin
				if (count == CNT_LAST) begin
					count      <= '0;               // restart block
					sum        <= '0;
					filt_valid <= 1'b1;             // one cycle after last sample
				end else begin
					count <= count + 1'b1;
					sum   <= sum_next;
				end
			end
		end
	end

	// average payload, valid alongside filt_valid
	always_ff @(posedge clk_in) begin
		if (adc_valid && count == CNT_LAST) begin
			filt_data <= W_IN'(avg);                // sign extend to pid width
		end
	end

endmodule

`default_nettype wire

/* hdl/lock_pkg.sv */
`default_nettype none

package lock_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int W_COEF = 16;                      // setpoint, coefs, error
	localparam int W_DAC  = 16;                      // dac word

	////////////////////////////////////////
	// command selectors
	////////////////////////////////////////

	localparam logic [3:0] SEL_SETPOINT = 4'h1;      // staged setpoint
	localparam logic [3:0] SEL_P        = 4'h2;      // staged p coef
	localparam logic [3:0] SEL_I        = 4'h3;      // staged i coef
	localparam logic [3:0] SEL_D        = 4'h4;      // staged d coef
	localparam logic [3:0] SEL_MANUAL   = 4'h5;      // manual output value
	localparam logic [3:0] SEL_CTRL     = 4'h8;      // flags and strobes

	// one 24-bit front-panel word, read as a write of a value or of flags
	typedef union packed {
		struct packed {
			logic [3:0]               sel;    // target select
			logic [3:0]               pad;    // unused
			logic signed [W_COEF-1:0] value;  // payload
		} param;
		struct packed {
			logic [3:0]  sel;                 // same position as param view
			logic        update_en;           // arms update
			logic        update;              // update strobe request
			logic        clear;               // clear strobe request
			logic        use_manual;          // manual source select
			logic [15:0] pad;                 // unused
		} ctrl;
	} lock_cmd_u;

endpackage

`default_nettype wire
